// File: hw/backEndPkg.sv
package backEndPkg;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------
    localparam int xlen     = 32;
    localparam int regAddrW = 5;
    localparam int memWords = 256;                  // data memory depth in words.
    localparam int memAddrW = $clog2(memWords);

    typedef enum logic [1:0] {
        resultAlu = 2'd0,
        resultMem = 2'd1,
        resultPc4 = 2'd2,
        resultPc8 = 2'd3
    } resultSrcT;

    // same encoding as the RV32I load/store funct3.
    typedef enum logic [2:0] {
        sizeByte  = 3'b000,
        sizeHalf  = 3'b001,
        sizeWord  = 3'b010,
        sizeByteU = 3'b100,
        sizeHalfU = 3'b101
    } accessSizeT;

    // ------------------------------------------------------------------------
    // stage payloads
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic              valid;
        logic              regWrite;
        resultSrcT         resultSrc;
        logic              memWrite;
        logic              memRead;
        accessSizeT        accessSize;
        logic [xlen-1:0]   aluResult;               // also the byte address for loads and stores.
        logic [xlen-1:0]   storeData;
        logic [regAddrW-1:0] rd;
        logic [xlen-1:0]   pcPlus4;
    } exMemT;

    typedef struct packed {
        logic              valid;
        logic              regWrite;
        resultSrcT         resultSrc;
        logic [xlen-1:0]   aluResult;
        logic [xlen-1:0]   readData;                // already extended.
        logic [regAddrW-1:0] rd;
        logic [xlen-1:0]   pcPlus4;
    } memWbT;

endpackage

// File: hw/memPortIf.sv
interface memPortIf;
    import backEndPkg::*;

    logic [memAddrW-1:0] addr;                      // word address.
    logic [xlen-1:0]     writeData;
    logic [3:0]          byteEn;
    logic                writeEn;
    logic [xlen-1:0]     readData;

    modport requester (
        output addr, writeData, byteEn, writeEn,
        input  readData
    );

    modport memory (
        input  addr, writeData, byteEn, writeEn,
        output readData
    );

endinterface

// File: hw/dualLaneRegister.sv
module dualLaneRegister #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    flush1,
    input  logic    flush2,
    input  logic    en1,
    input  logic    en2,
    input  payloadT in1,
    input  payloadT in2,
    output payloadT out1,
    output payloadT out2
);

    // each lane is independent, so one can be cancelled while the other moves on.
    // flush wins over enable and zeroes the whole payload, valid included.

    always_ff @(posedge clk) begin
        if (flush1) begin
            out1 <= '0;
        end else if (en1) begin
            out1 <= in1;
        end
    end

    always_ff @(posedge clk) begin
        if (flush2) begin
            out2 <= '0;
        end else if (en2) begin
            out2 <= in2;
        end
    end

endmodule

// File: hw/memoryAccess.sv
module memoryAccess (
    input  backEndPkg::exMemT mem1,
    input  backEndPkg::exMemT mem2,
    memPortIf.requester       port1,
    memPortIf.requester       port2,
    output backEndPkg::memWbT wb1,
    output backEndPkg::memWbT wb2
);
    import backEndPkg::*;

    // ------------------------------------------------------------------------
    // helpers shared by both lanes
    // ------------------------------------------------------------------------
    function automatic logic [memAddrW-1:0] wordAddr(exMemT m);
        return m.aluResult[memAddrW+1:2];
    endfunction

    function automatic logic [3:0] byteEnables(accessSizeT size, logic [1:0] offset);
        case (size)
            sizeByte, sizeByteU: return 4'b0001 << offset;
            sizeHalf, sizeHalfU: return offset[1] ? 4'b1100 : 4'b0011;
            default:             return 4'b1111;
        endcase
    endfunction

    // data is copied into every byte lane, the byte enables pick the right one.
    function automatic logic [xlen-1:0] alignStore(accessSizeT size, logic [xlen-1:0] data);
        case (size)
            sizeByte, sizeByteU: return {4{data[7:0]}};
            sizeHalf, sizeHalfU: return {2{data[15:0]}};
            default:             return data;
        endcase
    endfunction

    function automatic logic [xlen-1:0] extendLoad(accessSizeT size, logic [1:0] offset,
                                                   logic [xlen-1:0] word);
        logic [xlen-1:0] shifted;
        logic [7:0]      loadByte;
        logic [15:0]     loadHalf;
        shifted  = word >> {offset, 3'b000};
        loadByte = shifted[7:0];
        loadHalf = offset[1] ? word[31:16] : word[15:0];
        case (size)
            sizeByte:  return {{24{loadByte[7]}}, loadByte};
            sizeByteU: return {24'b0, loadByte};
            sizeHalf:  return {{16{loadHalf[15]}}, loadHalf};
            sizeHalfU: return {16'b0, loadHalf};
            default:   return word;
        endcase
    endfunction

    function automatic memWbT formWb(exMemT m, logic [xlen-1:0] rawWord);
        memWbT w;
        w.valid     = m.valid;
        w.regWrite  = m.regWrite;
        w.resultSrc = m.resultSrc;
        w.aluResult = m.aluResult;
        w.readData  = m.memRead ? extendLoad(m.accessSize, m.aluResult[1:0], rawWord) : '0;
        w.rd        = m.rd;
        w.pcPlus4   = m.pcPlus4;
        return w;
    endfunction

    // ------------------------------------------------------------------------
    // requests
    // ------------------------------------------------------------------------
    assign port1.addr      = wordAddr(mem1);
    assign port1.byteEn    = byteEnables(mem1.accessSize, mem1.aluResult[1:0]);
    assign port1.writeData = alignStore(mem1.accessSize, mem1.storeData);
    assign port1.writeEn   = mem1.valid && mem1.memWrite;   // bubbles never store.

    assign port2.addr      = wordAddr(mem2);
    assign port2.byteEn    = byteEnables(mem2.accessSize, mem2.aluResult[1:0]);
    assign port2.writeData = alignStore(mem2.accessSize, mem2.storeData);
    assign port2.writeEn   = mem2.valid && mem2.memWrite;

    // writeback payloads.
    assign wb1 = formWb(mem1, port1.readData);
    assign wb2 = formWb(mem2, port2.readData);

endmodule

// File: hw/dataMemory.sv
module dataMemory (
    input logic       clk,
    memPortIf.memory  port1,
    memPortIf.memory  port2
);
    import backEndPkg::*;

    logic [xlen-1:0] words [memWords];
    logic            sameWord;
    logic [3:0]      port2Owns;                     // bytes where port 2 overrides port 1.
    logic [xlen-1:0] port1Merged;

    assign sameWord  = port1.addr == port2.addr;
    assign port2Owns = (port2.writeEn && sameWord) ? port2.byteEn : 4'b0000;

    // ------------------------------------------------------------------------
    // writes, lane 2 is younger so its bytes win on a collision
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (port1.writeEn && port1.byteEn[b] && !port2Owns[b]) begin
                words[port1.addr][8*b +: 8] <= port1.writeData[8*b +: 8];
            end
            if (port2.writeEn && port2.byteEn[b]) begin
                words[port2.addr][8*b +: 8] <= port2.writeData[8*b +: 8];
            end
        end
    end

    // ------------------------------------------------------------------------
    // reads
    // ------------------------------------------------------------------------
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            port1Merged[8*b +: 8] = port1.byteEn[b] ? port1.writeData[8*b +: 8]
                                                    : words[port2.addr][8*b +: 8];
        end
    end

    assign port1.readData = words[port1.addr];

    // a lane-2 load sees the lane-1 store of the same cycle.
    assign port2.readData = (port1.writeEn && sameWord) ? port1Merged : words[port2.addr];

endmodule

// File: hw/pipelineControl.sv
module pipelineControl (
    input  logic        clk,
    input  logic        rst1,
    input  logic        stall,
    input  logic        flush1,
    input  logic        flush2,
    input  logic        wbValid1,
    input  logic        wbValid2,
    output logic        exMemFlush1,
    output logic        exMemFlush2,
    output logic        exMemEn1,
    output logic        exMemEn2,
    output logic        memWbFlush1,
    output logic        memWbFlush2,
    output logic        memWbEn1,
    output logic        memWbEn2,
    output logic [31:0] retired
);

    // flush beats stall in the register, so a flushed lane is dropped even when held.
    assign exMemFlush1 = rst1 || flush1;
    assign exMemFlush2 = rst1 || flush2;
    assign exMemEn1    = !stall;
    assign exMemEn2    = !stall;

    assign memWbFlush1 = rst1;
    assign memWbFlush2 = rst1;
    assign memWbEn1    = !stall;
    assign memWbEn2    = !stall;

    // an instruction retires when it leaves writeback.
    always_ff @(posedge clk) begin
        if (rst1) begin
            retired <= '0;
        end else if (!stall) begin
            retired <= retired + 32'(wbValid1) + 32'(wbValid2);
        end
    end

endmodule

// File: hw/writebackRegFile.sv
module writebackRegFile (
    input  logic                                clk,
    input  backEndPkg::memWbT                   wb1,
    input  backEndPkg::memWbT                   wb2,
    input  logic [backEndPkg::regAddrW-1:0]     readAddrA,
    input  logic [backEndPkg::regAddrW-1:0]     readAddrB,
    output logic [backEndPkg::xlen-1:0]         readDataA,
    output logic [backEndPkg::xlen-1:0]         readDataB
);
    import backEndPkg::*;

    logic [xlen-1:0] regs [2**regAddrW];
    logic [xlen-1:0] result1;
    logic [xlen-1:0] result2;
    logic            write1;
    logic            write2;

    function automatic logic [xlen-1:0] selectResult(memWbT w);
        case (w.resultSrc)
            resultMem: return w.readData;
            resultPc4: return w.pcPlus4;
            resultPc8: return w.pcPlus4 + xlen'(4);  // link past the paired slot.
            default:   return w.aluResult;
        endcase
    endfunction

    assign result1 = selectResult(wb1);
    assign result2 = selectResult(wb2);

    assign write1 = wb1.valid && wb1.regWrite && (wb1.rd != '0);
    assign write2 = wb2.valid && wb2.regWrite && (wb2.rd != '0);

    // ------------------------------------------------------------------------
    // two write ports, lane 2 last so it wins on the same rd
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (write1 && !(write2 && wb2.rd == wb1.rd)) begin
            regs[wb1.rd] <= result1;
        end
        if (write2) begin
            regs[wb2.rd] <= result2;
        end
    end

    // x0 is hardwired, its entry is never written.
    assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
    assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

// File: hw/backEndTop.sv
module backEndTop (
    input  logic                                clk,
    input  logic                                rst1,
    input  logic                                stall,
    input  logic                                flush1,
    input  logic                                flush2,

    input  logic                                validLane1,
    input  logic                                regWriteLane1,
    input  logic                                memWriteLane1,
    input  logic                                memReadLane1,
    input  logic [1:0]                          resultSrcLane1,
    input  logic [2:0]                          accessSizeLane1,
    input  logic [backEndPkg::xlen-1:0]         aluResultLane1,
    input  logic [backEndPkg::xlen-1:0]         storeDataLane1,
    input  logic [backEndPkg::regAddrW-1:0]     rdLane1,
    input  logic [backEndPkg::xlen-1:0]         pcPlus4Lane1,

    input  logic                                validLane2,
    input  logic                                regWriteLane2,
    input  logic                                memWriteLane2,
    input  logic                                memReadLane2,
    input  logic [1:0]                          resultSrcLane2,
    input  logic [2:0]                          accessSizeLane2,
    input  logic [backEndPkg::xlen-1:0]         aluResultLane2,
    input  logic [backEndPkg::xlen-1:0]         storeDataLane2,
    input  logic [backEndPkg::regAddrW-1:0]     rdLane2,
    input  logic [backEndPkg::xlen-1:0]         pcPlus4Lane2,

    input  logic [backEndPkg::regAddrW-1:0]     readAddrA,
    input  logic [backEndPkg::regAddrW-1:0]     readAddrB,
    output logic [backEndPkg::xlen-1:0]         readDataA,
    output logic [backEndPkg::xlen-1:0]         readDataB,
    output logic [31:0]                         retired
);
    import backEndPkg::*;

    exMemT exIn1, exIn2, memStage1, memStage2;
    memWbT wbIn1, wbIn2, wbStage1, wbStage2;

    logic exMemFlush1, exMemFlush2, exMemEn1, exMemEn2;
    logic memWbFlush1, memWbFlush2, memWbEn1, memWbEn2;

    memPortIf memPort1 ();
    memPortIf memPort2 ();

    // ------------------------------------------------------------------------
    // lane packing
    // ------------------------------------------------------------------------
    assign exIn1 = '{valid: validLane1, regWrite: regWriteLane1,
                     resultSrc: resultSrcT'(resultSrcLane1), memWrite: memWriteLane1,
                     memRead: memReadLane1, accessSize: accessSizeT'(accessSizeLane1),
                     aluResult: aluResultLane1, storeData: storeDataLane1,
                     rd: rdLane1, pcPlus4: pcPlus4Lane1};

    assign exIn2 = '{valid: validLane2, regWrite: regWriteLane2,
                     resultSrc: resultSrcT'(resultSrcLane2), memWrite: memWriteLane2,
                     memRead: memReadLane2, accessSize: accessSizeT'(accessSizeLane2),
                     aluResult: aluResultLane2, storeData: storeDataLane2,
                     rd: rdLane2, pcPlus4: pcPlus4Lane2};

    // ------------------------------------------------------------------------
    // pipeline
    // ------------------------------------------------------------------------
    pipelineControl control (
        .clk(clk), .rst1(rst1), .stall(stall), .flush1(flush1), .flush2(flush2),
        .wbValid1(wbStage1.valid), .wbValid2(wbStage2.valid),
        .exMemFlush1(exMemFlush1), .exMemFlush2(exMemFlush2),
        .exMemEn1(exMemEn1), .exMemEn2(exMemEn2),
        .memWbFlush1(memWbFlush1), .memWbFlush2(memWbFlush2),
        .memWbEn1(memWbEn1), .memWbEn2(memWbEn2),
        .retired(retired)
    );

    dualLaneRegister #(.payloadT(exMemT)) exMemReg (
        .clk(clk), .flush1(exMemFlush1), .flush2(exMemFlush2),
        .en1(exMemEn1), .en2(exMemEn2),
        .in1(exIn1), .in2(exIn2), .out1(memStage1), .out2(memStage2)
    );

    memoryAccess access (
        .mem1(memStage1), .mem2(memStage2),
        .port1(memPort1.requester), .port2(memPort2.requester),
        .wb1(wbIn1), .wb2(wbIn2)
    );

    dataMemory dmem (
        .clk(clk), .port1(memPort1.memory), .port2(memPort2.memory)
    );

    dualLaneRegister #(.payloadT(memWbT)) memWbReg (
        .clk(clk), .flush1(memWbFlush1), .flush2(memWbFlush2),
        .en1(memWbEn1), .en2(memWbEn2),
        .in1(wbIn1), .in2(wbIn2), .out1(wbStage1), .out2(wbStage2)
    );

    writebackRegFile regFile (
        .clk(clk), .wb1(wbStage1), .wb2(wbStage2),
        .readAddrA(readAddrA), .readAddrB(readAddrB),
        .readDataA(readDataA), .readDataB(readDataB)
    );

endmodule

// File: tests/backEndTb.sv
module backEndTb;
    import backEndPkg::*;

    localparam int stimCycles = 56;                 // reset plus issue, stall and drain cycles.
    localparam int cycleLimit = 4 * stimCycles + 50;

    logic clk;
    logic rst1;
    logic stall;
    logic flush1;
    logic flush2;
    logic [regAddrW-1:0] readAddrA;
    logic [regAddrW-1:0] readAddrB;
    logic [xlen-1:0]     readDataA;
    logic [xlen-1:0]     readDataB;
    logic [31:0]         retired;

    exMemT laneIn [1:2];                            // lanes presented to the DUT.
    int    seed = 24201;
    int    cycles = 0;

    // reference model state.
    logic [xlen-1:0] regModel [32];
    logic            regKnown [32];
    logic [xlen-1:0] memModel [memWords];
    exMemT           memStage [1:2];
    logic            wbValid [1:2];
    logic            wbWrite [1:2];
    logic [4:0]      wbRd [1:2];
    logic [xlen-1:0] wbValue [1:2];
    logic [4:0]      lastRd [1:2];                  // last destination each lane wrote.
    logic [31:0]     retiredModel;

    backEndTop uut (
        .clk(clk), .rst1(rst1), .stall(stall), .flush1(flush1), .flush2(flush2),
        .validLane1(laneIn[1].valid), .regWriteLane1(laneIn[1].regWrite),
        .memWriteLane1(laneIn[1].memWrite), .memReadLane1(laneIn[1].memRead),
        .resultSrcLane1(laneIn[1].resultSrc), .accessSizeLane1(laneIn[1].accessSize),
        .aluResultLane1(laneIn[1].aluResult), .storeDataLane1(laneIn[1].storeData),
        .rdLane1(laneIn[1].rd), .pcPlus4Lane1(laneIn[1].pcPlus4),
        .validLane2(laneIn[2].valid), .regWriteLane2(laneIn[2].regWrite),
        .memWriteLane2(laneIn[2].memWrite), .memReadLane2(laneIn[2].memRead),
        .resultSrcLane2(laneIn[2].resultSrc), .accessSizeLane2(laneIn[2].accessSize),
        .aluResultLane2(laneIn[2].aluResult), .storeDataLane2(laneIn[2].storeData),
        .rdLane2(laneIn[2].rd), .pcPlus4Lane2(laneIn[2].pcPlus4),
        .readAddrA(readAddrA), .readAddrB(readAddrB),
        .readDataA(readDataA), .readDataB(readDataB), .retired(retired)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic reportFail(string msg);
        $display("=== FAIL ===");
        $fatal(1, "%s", msg);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycleLimit) begin
            reportFail("simulation timed out before the tests finished");
        end
    end

    // ------------------------------------------------------------------------
    // model memory access by size
    // ------------------------------------------------------------------------
    task automatic storeModel(accessSizeT size, logic [31:0] addr, logic [31:0] data);
        logic [memAddrW-1:0] idx;
        idx = addr[memAddrW+1:2];
        case (size)
            sizeByte, sizeByteU: memModel[idx][8*addr[1:0] +: 8] = data[7:0];
            sizeHalf, sizeHalfU: begin
                if (addr[1]) memModel[idx][31:16] = data[15:0];
                else memModel[idx][15:0] = data[15:0];
            end
            default: memModel[idx] = data;
        endcase
    endtask

    function automatic logic [31:0] loadModel(accessSizeT size, logic [31:0] addr);
        logic [31:0] w;
        logic [7:0]  b;
        logic [15:0] h;
        w = memModel[addr[memAddrW+1:2]];
        b = w[8*addr[1:0] +: 8];
        h = addr[1] ? w[31:16] : w[15:0];
        case (size)
            sizeByte:  return {{24{b[7]}}, b};
            sizeByteU: return {24'h0, b};
            sizeHalf:  return {{16{h[15]}}, h};
            sizeHalfU: return {16'h0, h};
            default:   return w;
        endcase
    endfunction

    // model pipeline, lane 1 applied before lane 2.
    always @(posedge clk) begin
        if (rst1) begin
            for (int l = 1; l <= 2; l++) begin
                memStage[l] = '0;
                wbValid[l] = 1'b0;
                wbWrite[l] = 1'b0;
                lastRd[l] = '0;
            end
            retiredModel = '0;
        end else begin
            // a held writeback result writes the same value again on every edge.
            for (int l = 1; l <= 2; l++) begin
                if (wbValid[l] && wbWrite[l]) begin
                    lastRd[l] = wbRd[l];
                    if (wbRd[l] != 5'd0) begin
                        regModel[wbRd[l]] = wbValue[l];
                        regKnown[wbRd[l]] = 1'b1;
                    end
                end
            end
            for (int l = 1; l <= 2; l++) begin
                if (!stall) begin
                    if (wbValid[l]) retiredModel++;
                    wbValid[l] = memStage[l].valid;
                    wbWrite[l] = memStage[l].regWrite;
                    wbRd[l] = memStage[l].rd;
                    case (memStage[l].resultSrc)
                        resultMem: wbValue[l] = loadModel(memStage[l].accessSize,
                                                          memStage[l].aluResult);
                        resultPc4: wbValue[l] = memStage[l].pcPlus4;
                        resultPc8: wbValue[l] = memStage[l].pcPlus4 + 32'd4;
                        default:   wbValue[l] = memStage[l].aluResult;
                    endcase
                end
                if (memStage[l].valid && memStage[l].memWrite) begin
                    storeModel(memStage[l].accessSize, memStage[l].aluResult,
                               memStage[l].storeData);
                end
            end
            if (flush1) memStage[1] = '0;
            else if (!stall) memStage[1] = laneIn[1];
            if (flush2) memStage[2] = '0;
            else if (!stall) memStage[2] = laneIn[2];
        end
    end

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------
    checkReadA: assert property (@(negedge clk) disable iff (rst1)
        !regKnown[readAddrA] || readDataA == regModel[readAddrA])
        else begin
            $display("ERROR readDataA x%0d: got %h expected %h", readAddrA, readDataA,
                     regModel[readAddrA]);
            reportFail("register read port A mismatch");
        end

    checkReadB: assert property (@(negedge clk) disable iff (rst1)
        !regKnown[readAddrB] || readDataB == regModel[readAddrB])
        else begin
            $display("ERROR readDataB x%0d: got %h expected %h", readAddrB, readDataB,
                     regModel[readAddrB]);
            reportFail("register read port B mismatch");
        end

    checkRetired: assert property (@(negedge clk) disable iff (rst1)
        retired == retiredModel)
        else begin
            $display("ERROR retired: got %h expected %h", retired, retiredModel);
            reportFail("retired counter mismatch");
        end

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------
    function automatic logic [4:0] pickRd();
        int r;
        r = $random(seed);
        return 5'((r & 32'h7fffffff) % 31 + 1);
    endfunction

    function automatic exMemT aluOp(logic [4:0] rd, logic [31:0] value);
        exMemT p;
        p = '0;
        p.valid = 1'b1;
        p.regWrite = 1'b1;
        p.resultSrc = resultAlu;
        p.aluResult = value;
        p.rd = rd;
        return p;
    endfunction

    function automatic exMemT storeOp(accessSizeT size, int addr, logic [31:0] data);
        exMemT p;
        p = '0;
        p.valid = 1'b1;
        p.memWrite = 1'b1;
        p.accessSize = size;
        p.aluResult = 32'(addr);
        p.storeData = data;
        return p;
    endfunction

    function automatic exMemT loadOp(accessSizeT size, int addr, logic [4:0] rd);
        exMemT p;
        p = aluOp(rd, 32'(addr));
        p.resultSrc = resultMem;
        p.memRead = 1'b1;
        p.accessSize = size;
        return p;
    endfunction

    function automatic exMemT linkOp(resultSrcT src, logic [4:0] rd, logic [31:0] pc);
        exMemT p;
        p = aluOp(rd, 32'hdead0000);
        p.resultSrc = src;
        p.pcPlus4 = pc;
        return p;
    endfunction

    task automatic advance();
        @(posedge clk);
        #1;
        laneIn[1] = '0;
        laneIn[2] = '0;
        flush1 = 1'b0;
        flush2 = 1'b0;
        readAddrA = lastRd[1];                      // read back what each lane wrote last.
        readAddrB = lastRd[2];
    endtask

    task automatic issue(exMemT a, exMemT b);
        laneIn[1] = a;
        laneIn[2] = b;
        advance();
    endtask

    accessSizeT storeSizes [3] = '{sizeByte, sizeHalf, sizeWord};

    initial begin
        int off;
        rst1 = 1'b1;
        stall = 1'b0;
        flush1 = 1'b0;
        flush2 = 1'b0;
        readAddrA = '0;
        readAddrB = '0;
        laneIn[1] = '0;
        laneIn[2] = '0;
        for (int i = 0; i < 32; i++) regKnown[i] = 1'b0;
        regKnown[0] = 1'b1;                         // x0 always reads zero.
        regModel[0] = '0;
        repeat (5) @(posedge clk);
        #1;
        rst1 = 1'b0;

        // fill words 0..15 so every later load sees known data.
        for (int w = 0; w < 16; w += 2) begin
            issue(storeOp(sizeWord, 4*w, $random(seed)),
                  storeOp(sizeWord, 4*w+4, $random(seed)));
        end

        for (int i = 0; i < 10; i++) begin
            issue(aluOp(pickRd(), $random(seed)), aluOp((i % 3 == 0) ? 5'd0 : pickRd(),
                                                        $random(seed)));
        end

        foreach (storeSizes[s]) begin
            off = (s == 0) ? ($random(seed) & 3) : ((s == 1) ? 2 : 0);
            issue(storeOp(storeSizes[s], 12 + off, $random(seed)), '0);
            issue(loadOp(sizeByte, 12 + off, pickRd()), loadOp(sizeByteU, 12 + off, pickRd()));
            issue(loadOp(sizeHalf, 12 + (off & 2), pickRd()),
                  loadOp(sizeHalfU, 12 + (off & 2), pickRd()));
            issue(loadOp(sizeWord, 12, pickRd()), linkOp(resultPc8, pickRd(), $random(seed)));
        end
        issue(linkOp(resultPc4, pickRd(), $random(seed)), linkOp(resultPc8, pickRd(), 32'h100));

        // same-cycle conflicts between the lanes.
        issue(storeOp(sizeHalf, 22, $random(seed)), loadOp(sizeWord, 20, pickRd()));
        issue(storeOp(sizeWord, 24, $random(seed)), storeOp(sizeByte, 25, $random(seed)));
        issue(aluOp(5'd7, $random(seed)), aluOp(5'd7, $random(seed)));
        issue(loadOp(sizeWord, 24, pickRd()), '0);

        // stall with results still in flight.
        issue(aluOp(5'd11, $random(seed)), aluOp(5'd12, $random(seed)));
        issue(aluOp(5'd13, $random(seed)), aluOp(5'd11, $random(seed)));
        stall = 1'b1;
        repeat (4) advance();
        stall = 1'b0;

        // flush one lane while the other completes.
        flush1 = 1'b1;
        issue(storeOp(sizeWord, 28, $random(seed)), aluOp(5'd9, $random(seed)));
        flush2 = 1'b1;
        issue(aluOp(5'd10, $random(seed)), storeOp(sizeWord, 32, $random(seed)));
        flush2 = 1'b1;
        issue(aluOp(5'd14, $random(seed)), aluOp(5'd9, $random(seed)));
        issue(loadOp(sizeWord, 28, 5'd15), loadOp(sizeWord, 32, 5'd16));

        repeat (6) advance();
        if (retired !== retiredModel) begin
            $display("ERROR retired: got %h expected %h", retired, retiredModel);
            reportFail("retired counter mismatch after drain");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

// File: verilog.f
hw/backEndPkg.sv
hw/memPortIf.sv
hw/dualLaneRegister.sv
hw/memoryAccess.sv
hw/dataMemory.sv
hw/pipelineControl.sv
hw/writebackRegFile.sv
hw/backEndTop.sv
tests/backEndTb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := backEndTb
FILELIST := verilog.f
LOG      := sim.log

OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
SRCS     := $(wildcard hw/*.sv tests/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then exit 1; fi
	@grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
